// File: include/general_defs.svh
`ifndef GENERAL_DEFS_SVH
`define GENERAL_DEFS_SVH

// Address and program counter width.
`define WORD 32

// Instruction width.
`define HALF_WORD 16

// Number of half-word entries in the instruction RAM.
`define IMEM_DEPTH 512

// First fetch address after a start command.
`define RESET_PC 0

`endif

// File: hw/fetch_pkg.sv
`default_nettype none

`include "general_defs.svh"

package fetch_pkg;

    typedef enum logic {
        NO_FLUSH,
        FLUSH_PIPELINE
    } flush_pipeline_sig;

    typedef enum logic {
        NO_STALL,
        STALL_PIPELINE
    } stall_pipeline_sig;

    // Branch redirect coming back from a later stage.
    typedef struct packed {
        logic              valid;
        logic [`WORD-1:0]  target;
    } redirect_t;

    typedef struct packed {
        logic                   valid;
        logic [`HALF_WORD-1:0]  instr;
        logic [`WORD-1:0]       pc;
    } fetch_bundle_t;

    // Program load port. The addr field is a byte address.
    typedef struct packed {
        logic                   en;
        logic [`WORD-1:0]       addr;
        logic [`HALF_WORD-1:0]  data;
    } prog_write_t;

endpackage

`default_nettype wire

// File: hw/instruction_ram.sv
`default_nettype none

`include "general_defs.svh"

module instruction_ram (
    input  wire logic                  clk_i,
    input  wire logic                  write_en_i,
    input  wire logic [`WORD-1:0]      instruction_addr_i,
    input  wire logic [`HALF_WORD-1:0] data_i,

    output logic [`HALF_WORD-1:0]      instruction_o
);

    localparam int ADDR_BITS = $clog2(`IMEM_DEPTH);

    logic [`HALF_WORD-1:0] mem [`IMEM_DEPTH];
    logic [ADDR_BITS-1:0]  index;

    // Entries are half-words, so bit 0 of the byte address is dropped.
    assign index = instruction_addr_i[ADDR_BITS:1];

    always_ff @(posedge clk_i) begin
        if (write_en_i) begin
            mem[index] <= data_i;
        end
    end

    // The read port returns the old contents on a write cycle.
    always_ff @(posedge clk_i) begin
        instruction_o <= mem[index];
    end

endmodule

`default_nettype wire

// File: hw/instruction_mem.sv
`default_nettype none

`include "general_defs.svh"

module instruction_mem (
    input  wire logic                          clk_i,
    input  wire logic                          reset_i,
    input  wire logic                          program_mem_write_en_i,
    input  wire logic                          is_valid_i,
    input  wire fetch_pkg::flush_pipeline_sig  flush_pipeline_i,
    input  wire fetch_pkg::stall_pipeline_sig  stall_pipeline_i,
    input  wire logic [`HALF_WORD-1:0]         instruction_i,
    input  wire logic [`WORD-1:0]              instruction_addr_i,

    output logic                               is_valid_o,
    output logic [`HALF_WORD-1:0]              instruction_o,
    output logic [`WORD-1:0]                   program_counter_o
);

    import fetch_pkg::*;

    logic [`WORD-1:0] next_instruction_addr;

    // On a stall the RAM is read again at the address already on the output,
    // so the output pair stays the same for the next cycle.
    always_comb begin
        if (program_mem_write_en_i) begin
            next_instruction_addr = instruction_addr_i;
        end else if (stall_pipeline_i == STALL_PIPELINE) begin
            next_instruction_addr = program_counter_o;
        end else begin
            next_instruction_addr = instruction_addr_i;
        end
    end

    instruction_ram ram (
        .clk_i              (clk_i),
        .write_en_i         (program_mem_write_en_i),
        .instruction_addr_i (next_instruction_addr),
        .data_i             (instruction_i),
        .instruction_o      (instruction_o)
    );

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            is_valid_o <= 1'b0;
        end else if (flush_pipeline_i == FLUSH_PIPELINE) begin
            is_valid_o <= 1'b0;
        end else begin
            is_valid_o <= is_valid_i;
        end
    end

    // Registered alongside the RAM read so pc and instruction line up.
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            program_counter_o <= '0;
        end else begin
            program_counter_o <= next_instruction_addr;
        end
    end

endmodule

`default_nettype wire

// File: hw/pc_gen.sv
`default_nettype none

`include "general_defs.svh"

module pc_gen (
    input  wire logic                   clk_i,
    input  wire logic                   reset_i,
    input  wire logic                   restart_i,
    input  wire logic                   advance_i,
    input  wire fetch_pkg::redirect_t   redirect_i,
    input  wire fetch_pkg::prog_write_t prog_i,

    output logic [`WORD-1:0]            fetch_addr_o
);

    import fetch_pkg::*;

    localparam logic [`WORD-1:0] START_ADDR = `WORD'(`RESET_PC);
    localparam logic [`WORD-1:0] INSTR_STEP = `WORD'(2);

    logic [`WORD-1:0] pc_q;
    logic [`WORD-1:0] pc_d;
    logic [`WORD-1:0] target;

    // Instructions are half-word aligned.
    assign target = {redirect_i.target[`WORD-1:1], 1'b0};

    // Start has priority so a start always begins at the reset address.
    always_comb begin
        if (restart_i) begin
            pc_d = START_ADDR;
        end else if (redirect_i.valid) begin
            pc_d = target;
        end else if (advance_i) begin
            pc_d = pc_q + INSTR_STEP;
        end else begin
            pc_d = pc_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pc_q <= '0;
        end else begin
            pc_q <= pc_d;
        end
    end

    // While loading a program the RAM follows the write address instead.
    always_comb begin
        if (prog_i.en) begin
            fetch_addr_o = prog_i.addr;
        end else begin
            fetch_addr_o = pc_q;
        end
    end

endmodule

`default_nettype wire

// File: hw/fetch_control.sv
`default_nettype none

module fetch_control (
    input  wire logic                   clk_i,
    input  wire logic                   reset_i,
    input  wire logic                   start_i,
    input  wire logic                   halt_i,
    input  wire logic                   stall_i,
    input  wire fetch_pkg::redirect_t   redirect_i,
    input  wire logic                   prog_en_i,

    output fetch_pkg::stall_pipeline_sig stall_pipeline_o,
    output fetch_pkg::flush_pipeline_sig flush_pipeline_o,
    output logic                         fetch_valid_o,
    output logic                         restart_o,
    output logic                         advance_o
);

    import fetch_pkg::*;

    typedef enum logic {
        HALT,
        RUN
    } state_t;

    state_t state_q;
    state_t state_d;
    logic   pending_q;
    logic   pending_d;
    logic   running;
    logic   hold;
    logic   redirect;

    assign running  = (state_q == RUN);
    assign redirect = running && redirect_i.valid;

    // A redirect in the same cycle wins over the downstream stall.
    assign hold = running && stall_i && !redirect_i.valid;

    assign stall_pipeline_o = hold ? STALL_PIPELINE : NO_STALL;

    // Restarting while running drops the one instruction already in flight.
    assign flush_pipeline_o = (halt_i || redirect || (running && start_i)) ?
                              FLUSH_PIPELINE : NO_FLUSH;

    assign restart_o = start_i && !halt_i;
    assign advance_o = running && !hold && !redirect_i.valid;

    // pending_q marks a cycle whose output is still the flushed bubble.
    // Holding it under a stall must keep the bubble invalid.
    assign fetch_valid_o = running && !prog_en_i && !(pending_q && hold);

    always_comb begin
        state_d   = state_q;
        pending_d = pending_q;
        if (halt_i) begin
            state_d   = HALT;
            pending_d = 1'b0;
        end else if (start_i) begin
            state_d   = RUN;
            pending_d = 1'b1;
        end else if (redirect) begin
            pending_d = 1'b1;
        end else if (running && !hold) begin
            pending_d = 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q   <= HALT;
            pending_q <= 1'b0;
        end else begin
            state_q   <= state_d;
            pending_q <= pending_d;
        end
    end

endmodule

`default_nettype wire

// File: hw/fetch_top.sv
`default_nettype none

`include "general_defs.svh"

module fetch_top (
    input  wire logic                   clk_i,
    input  wire logic                   reset_i,
    input  wire fetch_pkg::prog_write_t prog_i,
    input  wire logic                   start_i,
    input  wire logic                   halt_i,
    input  wire logic                   stall_i,
    input  wire fetch_pkg::redirect_t   redirect_i,

    output fetch_pkg::fetch_bundle_t    fetch_o
);

    import fetch_pkg::*;

    stall_pipeline_sig     stall_pipeline;
    flush_pipeline_sig     flush_pipeline;
    logic                  fetch_valid;
    logic                  restart;
    logic                  advance;
    logic [`WORD-1:0]      fetch_addr;
    logic                  mem_valid;
    logic [`HALF_WORD-1:0] mem_instr;
    logic [`WORD-1:0]      mem_pc;

    fetch_control u_control (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .start_i          (start_i),
        .halt_i           (halt_i),
        .stall_i          (stall_i),
        .redirect_i       (redirect_i),
        .prog_en_i        (prog_i.en),
        .stall_pipeline_o (stall_pipeline),
        .flush_pipeline_o (flush_pipeline),
        .fetch_valid_o    (fetch_valid),
        .restart_o        (restart),
        .advance_o        (advance)
    );

    pc_gen u_pc_gen (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .restart_i    (restart),
        .advance_i    (advance),
        .redirect_i   (redirect_i),
        .prog_i       (prog_i),
        .fetch_addr_o (fetch_addr)
    );

    instruction_mem u_imem (
        .clk_i                  (clk_i),
        .reset_i                (reset_i),
        .program_mem_write_en_i (prog_i.en),
        .is_valid_i             (fetch_valid),
        .flush_pipeline_i       (flush_pipeline),
        .stall_pipeline_i       (stall_pipeline),
        .instruction_i          (prog_i.data),
        .instruction_addr_i     (fetch_addr),
        .is_valid_o             (mem_valid),
        .instruction_o          (mem_instr),
        .program_counter_o      (mem_pc)
    );

    assign fetch_o = '{valid: mem_valid, instr: mem_instr, pc: mem_pc};

endmodule

`default_nettype wire

// File: tb/fetch_checker.sv
`default_nettype none

module fetch_checker (
    input  wire logic                         clk_i,
    input  wire logic                         reset_i,
    input  wire logic                         running_i,
    input  wire logic                         halt_i,
    input  wire logic                         prog_en_i,
    input  wire logic                         fetch_valid_i,
    input  wire logic                         advance_i,
    input  wire fetch_pkg::flush_pipeline_sig flush_pipeline_i,
    input  wire fetch_pkg::stall_pipeline_sig stall_pipeline_i
);

    import fetch_pkg::*;

    int flush_fails = 0;
    int valid_fails = 0;
    int overlap_fails = 0;
    int fail_count;

    assign fail_count = flush_fails + valid_fails + overlap_fails;

    // While halted only a halt request may raise the flush.
    flush_when_halted: assert property (@(posedge clk_i) disable iff (reset_i)
        (!running_i && !halt_i) |-> (flush_pipeline_i == NO_FLUSH))
        else begin
            $error("Flush raised while halted without a halt request");
            flush_fails++;
        end

    valid_while_programming: assert property (@(posedge clk_i) disable iff (reset_i)
        prog_en_i |-> !fetch_valid_i)
        else begin
            $error("Fetch valid raised during program load");
            valid_fails++;
        end

    advance_while_stalled: assert property (@(posedge clk_i) disable iff (reset_i)
        !(advance_i && (stall_pipeline_i == STALL_PIPELINE)))
        else begin
            $error("Program counter advanced during a stall");
            overlap_fails++;
        end

endmodule

bind fetch_control fetch_checker u_checker (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .running_i        (running),
    .halt_i           (halt_i),
    .prog_en_i        (prog_en_i),
    .fetch_valid_i    (fetch_valid_o),
    .advance_i        (advance_o),
    .flush_pipeline_i (flush_pipeline_o),
    .stall_pipeline_i (stall_pipeline_o)
);

`default_nettype wire

// File: tb/fetch_monitor.sv
`default_nettype none

`include "general_defs.svh"

module fetch_monitor #(
    parameter int LAST_TEST = 5
) (
    input  wire logic                     clk_i,
    input  wire logic                     reset_i,
    input  wire fetch_pkg::prog_write_t   prog_i,
    input  wire logic                     start_i,
    input  wire logic                     halt_i,
    input  wire logic                     stall_i,
    input  wire fetch_pkg::redirect_t     redirect_i,
    input  wire fetch_pkg::fetch_bundle_t fetch_i,
    input  int                            test_id_i,
    input  int                            assert_fails_i,

    output int                            errors_o
);

    import fetch_pkg::*;

    localparam int INDEX_BITS = $clog2(`IMEM_DEPTH);

    typedef struct packed {
        logic             running;
        logic [`WORD-1:0] pc_next;
        fetch_bundle_t    out;
    } model_t;

    logic [`HALF_WORD-1:0] image [`IMEM_DEPTH];
    model_t                model;
    int                    current_test = 0;
    int                    checks = 0;
    int                    test_errors = 0;
    int                    failed_tests = 0;
    int                    value_errors = 0;

    assign errors_o = value_errors;

    // Expected output of the next cycle from the inputs seen in this one.
    function automatic model_t predict(model_t m, logic start, logic halt, logic stall,
                                       redirect_t redir, logic prog_en);
        model_t n;
        n = m;
        n.out.valid = 1'b0;
        if (halt) begin
            n.running = 1'b0;
        end else if (prog_en) begin
            n.running = m.running;
        end else if (start) begin
            n.running = 1'b1;
            n.pc_next = `WORD'(`RESET_PC);
        end else if (m.running && redir.valid) begin
            n.pc_next = redir.target;
        end else if (m.running && stall) begin
            n.out = m.out;
        end else if (m.running) begin
            n.out.valid = 1'b1;
            n.out.pc = m.pc_next;
            n.out.instr = image[m.pc_next[INDEX_BITS:1]];
            n.pc_next = m.pc_next + `WORD'(2);
        end
        return n;
    endfunction

    function automatic string test_name(int id);
        case (id)
            1: return "idle after reset";
            2: return "sequential fetch";
            3: return "random stalls";
            4: return "redirects";
            default: return "halt and reprogram";
        endcase
    endfunction

    task automatic compare_field(string name, logic [`WORD-1:0] actual,
                                 logic [`WORD-1:0] expected);
        checks++;
        if (actual !== expected) begin
            $display("Fail at time %0t: %s expected %h got %h", $time, name, expected, actual);
            test_errors++;
            value_errors++;
        end
    endtask

    task automatic report_test();
        if (current_test != 0) begin
            $display("Test %0d (%s): %s, %0d checks, %0d errors", current_test,
                     test_name(current_test), (test_errors == 0) ? "passed" : "failed",
                     checks, test_errors);
            if (test_errors != 0) begin
                failed_tests++;
            end
        end
        checks = 0;
        test_errors = 0;
    endtask

    always @(posedge clk_i) begin
        if (reset_i) begin
            model = '0;
        end else if (current_test <= LAST_TEST) begin
            compare_field("fetch_o.valid", `WORD'(fetch_i.valid), `WORD'(model.out.valid));
            if (model.out.valid) begin
                compare_field("fetch_o.pc", fetch_i.pc, model.out.pc);
                compare_field("fetch_o.instr", `WORD'(fetch_i.instr), `WORD'(model.out.instr));
            end
            model = predict(model, start_i, halt_i, stall_i, redirect_i, prog_i.en);
            if (prog_i.en) begin
                image[prog_i.addr[INDEX_BITS:1]] = prog_i.data;
            end
        end
        if (test_id_i != current_test) begin
            report_test();
            current_test = test_id_i;
            if (current_test > LAST_TEST) begin
                $display("Tests: %0d, failed tests: %0d, value errors: %0d, assertion failures: %0d",
                         LAST_TEST, failed_tests, value_errors, assert_fails_i);
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/fetch_tb.sv
`default_nettype none

`include "general_defs.svh"

module fetch_tb;

    import fetch_pkg::*;

    localparam int RESET_CYCLES   = 8;
    localparam int IDLE_CYCLES    = 20;
    localparam int LOAD_CYCLES    = `IMEM_DEPTH + 1;
    localparam int RUN_CYCLES     = 40;
    localparam int STALL_BURSTS   = 8;
    localparam int REDIRECTS      = 6;
    localparam int DRAIN_CYCLES   = 4;
    localparam int LAST_TEST      = 5;
    localparam int TEST_CYCLES    = IDLE_CYCLES + LOAD_CYCLES + 2 + RUN_CYCLES
                                  + STALL_BURSTS * 10 + DRAIN_CYCLES + REDIRECTS * 10
                                  + 2 + 10 + LOAD_CYCLES + 2 + RUN_CYCLES + DRAIN_CYCLES;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + TEST_CYCLES + 200;

    logic          clk;
    logic          reset;
    prog_write_t   prog;
    logic          start;
    logic          halt;
    logic          stall;
    redirect_t     redirect;
    fetch_bundle_t fetch;
    logic [31:0]   rng_state;
    int            test_id;
    int            value_errors;
    int            assert_fails;
    int            cycles = 0;

    fetch_top DUT (
        .clk_i      (clk),
        .reset_i    (reset),
        .prog_i     (prog),
        .start_i    (start),
        .halt_i     (halt),
        .stall_i    (stall),
        .redirect_i (redirect),
        .fetch_o    (fetch)
    );

    fetch_monitor #(.LAST_TEST(LAST_TEST)) monitor (
        .clk_i          (clk),
        .reset_i        (reset),
        .prog_i         (prog),
        .start_i        (start),
        .halt_i         (halt),
        .stall_i        (stall),
        .redirect_i     (redirect),
        .fetch_i        (fetch),
        .test_id_i      (test_id),
        .assert_fails_i (assert_fails),
        .errors_o       (value_errors)
    );

    assign assert_fails = DUT.u_control.u_checker.fail_count;

    initial begin
        clk = 1'b0;
        forever begin
            #10;
            clk = ~clk;
        end
    end

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic random_below(input int limit, output int value);
        rng_state = xorshift(rng_state);
        value = int'(rng_state[15:0]) % limit;
    endtask

    task automatic wait_cycles(input int count);
        repeat (count) @(posedge clk);
    endtask

    // Fills every RAM entry with a fresh random half-word.
    task automatic load_program();
        int value;
        for (int i = 0; i < `IMEM_DEPTH; i++) begin
            random_below(65536, value);
            @(posedge clk);
            prog <= '{en: 1'b1, addr: `WORD'(i * 2), data: value[15:0]};
        end
        @(posedge clk);
        prog <= '0;
    endtask

    task automatic pulse_start();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic pulse_halt();
        @(posedge clk);
        halt <= 1'b1;
        @(posedge clk);
        halt <= 1'b0;
    endtask

    task automatic run_stalls();
        int run_len;
        int stall_len;
        for (int b = 0; b < STALL_BURSTS; b++) begin
            random_below(4, run_len);
            random_below(6, stall_len);
            wait_cycles(run_len + 1);
            stall <= 1'b1;
            wait_cycles(stall_len + 1);
            stall <= 1'b0;
        end
    endtask

    // Every second redirect arrives in the middle of a stall that outlasts it.
    task automatic run_redirects();
        int target;
        for (int k = 0; k < REDIRECTS; k++) begin
            random_below(400, target);
            if (k % 2 == 1) begin
                wait_cycles(1);
                stall <= 1'b1;
            end
            wait_cycles(1);
            redirect <= '{valid: 1'b1, target: `WORD'(target * 2)};
            wait_cycles(1);
            redirect <= '0;
            if (k % 2 == 1) begin
                wait_cycles(1);
                stall <= 1'b0;
            end
            wait_cycles(6);
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        reset = 1'b1;
        prog = '0;
        start = 1'b0;
        halt = 1'b0;
        stall = 1'b0;
        redirect = '0;
        test_id = 0;
        rng_state = 32'hb44d_35bd;
        wait_cycles(RESET_CYCLES);
        reset <= 1'b0;
        test_id <= 1;
        wait_cycles(IDLE_CYCLES);
        test_id <= 2;
        load_program();
        pulse_start();
        wait_cycles(RUN_CYCLES);
        test_id <= 3;
        run_stalls();
        wait_cycles(DRAIN_CYCLES);
        test_id <= 4;
        run_redirects();
        test_id <= 5;
        pulse_halt();
        wait_cycles(10);
        load_program();
        pulse_start();
        wait_cycles(RUN_CYCLES);
        wait_cycles(DRAIN_CYCLES);
        test_id <= LAST_TEST + 1;
        wait_cycles(2);
        if (value_errors == 0 && assert_fails == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+include
hw/fetch_pkg.sv
hw/instruction_ram.sv
hw/instruction_mem.sv
hw/pc_gen.sv
hw/fetch_control.sv
hw/fetch_top.sv
tb/fetch_checker.sv
tb/fetch_monitor.sv
tb/fetch_tb.sv

// File: Makefile
TOP := fetch_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): all.f $(wildcard hw/*.sv tb/*.sv include/*.svh)
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 > sim.log 2>&1 || true
	cat sim.log
	grep -qx "Finished with no errors" sim.log

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
